/* rtl/cpuPkg.sv */
`default_nettype none

package cpuPkg;

    // ***********************************************************
    // Widths
    // ***********************************************************
    typedef logic [31:0] instWord;
    typedef logic [31:0] addrWord;
    typedef logic [31:0] immWord;
    typedef logic [4:0]  regName;

    localparam int ROB_SIZE = 8;
    typedef logic [$clog2(ROB_SIZE)-1:0] robTag;

    localparam addrWord RESET_PC = 32'h0000_0000;

    // ***********************************************************
    // Major opcodes
    // ***********************************************************
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;

    // Decoded operation
    typedef enum logic [5:0] {
        LUI,
        AUIPC,
        JAL,
        JALR,
        // Branches
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        // Loads and stores
        LB,
        LH,
        LW,
        LBU,
        LHU,
        SB,
        SH,
        SW,
        // Register-immediate
        ADDI, SLTI, SLTIU, XORI, ORI, ANDI,
        SLLI,
        SRLI,
        SRAI,
        // Register-register
        ADD, SUB, SLL, SLT, SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        NOP          // Anything not recognized
    } opKind;

endpackage

`default_nettype wire

/* rtl/decodeIf.sv */
`timescale 1ns/1ns
`default_nettype none

interface decodeIf;

    logic            valid;
    logic            ready;
    cpuPkg::opKind   op;
    cpuPkg::regName  rs1;
    cpuPkg::regName  rs2;
    cpuPkg::regName  rd;
    cpuPkg::immWord  imm;
    cpuPkg::addrWord pc;
    logic            predTaken;

    // Decoder drives the record
    modport decodeSide (
        output valid, op, rs1, rs2, rd, imm, pc, predTaken,
        input  ready
    );

    modport renameSide (
        input  valid, op, rs1, rs2, rd, imm, pc, predTaken,
        output ready
    );

endinterface

`default_nettype wire

/* rtl/fetchIf.sv */
`timescale 1ns/1ns
`default_nettype none

interface fetchIf;

    logic            valid;
    logic            ready;
    cpuPkg::instWord inst;
    cpuPkg::addrWord pc;
    logic            predTaken;   // Static guess made at fetch

    modport fetchSide (
        output valid, inst, pc, predTaken,
        input  ready
    );

    modport decodeSide (
        input  valid, inst, pc, predTaken,
        output ready
    );

endinterface

`default_nettype wire

/* rtl/frontEnd.sv */
`timescale 1ns/1ns
`default_nettype none

module frontEnd (
    input  wire                  clk,
    input  wire                  rst,
    // Wishbone instruction bus
    output logic                 wbCyc,
    output logic                 wbStb,
    output logic                 wbWe,
    output cpuPkg::addrWord      wbAdr,
    input  wire cpuPkg::instWord wbDatI,
    input  wire                  wbAck,
    input  wire                  redirectEn,
    input  wire cpuPkg::addrWord redirectPc,
    input  wire                  commitEn,
    // Issue record
    input  wire                  issueReady,
    output logic                 issueValid,
    output cpuPkg::opKind        issueOp,
    output cpuPkg::robTag        issueRs1Tag,
    output cpuPkg::robTag        issueRs2Tag,
    output cpuPkg::robTag        issueRdTag,
    output logic                 issueRs1Busy,
    output logic                 issueRs2Busy,
    output cpuPkg::regName       issueRd,
    output cpuPkg::immWord       issueImm,
    output cpuPkg::addrWord      issuePc,
    output logic                 issuePredTaken
);

    fetchIf  fetchBus ();
    decodeIf decodeBus ();

    instFetch i_instFetch (
        .clk, .rst, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatI, .wbAck,
        .redirectEn, .redirectPc,
        .fetchOut (fetchBus.fetchSide)
    );

    instDecoder i_instDecoder (
        .clk, .rst, .redirectEn,
        .fetchIn   (fetchBus.decodeSide),
        .decodeOut (decodeBus.decodeSide)
    );

    renameStage i_renameStage (
        .clk, .rst, .redirectEn, .commitEn, .issueReady,
        .decodeIn (decodeBus.renameSide),
        .issueValid, .issueOp, .issueRs1Tag, .issueRs2Tag, .issueRdTag,
        .issueRs1Busy, .issueRs2Busy, .issueRd, .issueImm, .issuePc, .issuePredTaken
    );

endmodule

`default_nettype wire

/* rtl/instDecoder.sv */
`timescale 1ns/1ns
`default_nettype none

module instDecoder (
    input  wire         clk,
    input  wire         rst,
    fetchIf.decodeSide  fetchIn,
    decodeIf.decodeSide decodeOut,
    input  wire         redirectEn
);

    cpuPkg::instWord inst;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            alt;         // funct7 bit 30
    cpuPkg::immWord  immNext;
    cpuPkg::opKind   opNext;
    logic            outValid;
    logic            take;

    assign inst   = fetchIn.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign alt    = inst[30];

    assign fetchIn.ready   = !outValid || decodeOut.ready;
    assign take            = fetchIn.valid && fetchIn.ready;
    assign decodeOut.valid = outValid;

    // ***********************************************************
    // Immediate formats
    // ***********************************************************
    always_comb begin
        case (opcode)
            cpuPkg::OP_LUI,
            cpuPkg::OP_AUIPC:  immNext = {inst[31:12], 12'b0};
            cpuPkg::OP_JAL:    immNext = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            cpuPkg::OP_BRANCH: immNext = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            cpuPkg::OP_JALR,
            cpuPkg::OP_LOAD,
            cpuPkg::OP_IMM:    immNext = {{21{inst[31]}}, inst[30:20]};
            cpuPkg::OP_STORE:  immNext = {{21{inst[31]}}, inst[30:25], inst[11:7]};
            default:           immNext = '0;   // R-type has none
        endcase
    end

    // Operation select
    always_comb begin
        opNext = cpuPkg::NOP;
        case (opcode)
            cpuPkg::OP_LUI:   opNext = cpuPkg::LUI;
            cpuPkg::OP_AUIPC: opNext = cpuPkg::AUIPC;
            cpuPkg::OP_JAL:   opNext = cpuPkg::JAL;
            cpuPkg::OP_JALR:  opNext = cpuPkg::JALR;
            cpuPkg::OP_BRANCH: begin
                case (funct3)
                    3'b000:  opNext = cpuPkg::BEQ;
                    3'b001:  opNext = cpuPkg::BNE;
                    3'b100:  opNext = cpuPkg::BLT;
                    3'b101:  opNext = cpuPkg::BGE;
                    3'b110:  opNext = cpuPkg::BLTU;
                    3'b111:  opNext = cpuPkg::BGEU;
                    default: opNext = cpuPkg::NOP;
                endcase
            end
            cpuPkg::OP_LOAD: begin
                case (funct3)
                    3'b000:  opNext = cpuPkg::LB;
                    3'b001:  opNext = cpuPkg::LH;
                    3'b010:  opNext = cpuPkg::LW;
                    3'b100:  opNext = cpuPkg::LBU;
                    3'b101:  opNext = cpuPkg::LHU;
                    default: opNext = cpuPkg::NOP;
                endcase
            end
            cpuPkg::OP_STORE: begin
                case (funct3)
                    3'b000:  opNext = cpuPkg::SB;
                    3'b001:  opNext = cpuPkg::SH;
                    3'b010:  opNext = cpuPkg::SW;
                    default: opNext = cpuPkg::NOP;
                endcase
            end
            cpuPkg::OP_IMM: begin
                case (funct3)
                    3'b000: opNext = cpuPkg::ADDI;
                    3'b010: opNext = cpuPkg::SLTI;
                    3'b011: opNext = cpuPkg::SLTIU;
                    3'b100: opNext = cpuPkg::XORI;
                    3'b110: opNext = cpuPkg::ORI;
                    3'b111: opNext = cpuPkg::ANDI;
                    3'b001: opNext = alt ? cpuPkg::NOP : cpuPkg::SLLI;
                    3'b101: opNext = alt ? cpuPkg::SRAI : cpuPkg::SRLI;
                    default: opNext = cpuPkg::NOP;
                endcase
            end
            cpuPkg::OP_REG: begin
                case ({alt, funct3})
                    4'b0000: opNext = cpuPkg::ADD;
                    4'b1000: opNext = cpuPkg::SUB;
                    4'b0001: opNext = cpuPkg::SLL;
                    4'b0010: opNext = cpuPkg::SLT;
                    4'b0011: opNext = cpuPkg::SLTU;
                    4'b0100: opNext = cpuPkg::XOR;
                    4'b0101: opNext = cpuPkg::SRL;
                    4'b1101: opNext = cpuPkg::SRA;
                    4'b0110: opNext = cpuPkg::OR;
                    4'b0111: opNext = cpuPkg::AND;
                    default: opNext = cpuPkg::NOP;
                endcase
            end
            default: opNext = cpuPkg::NOP;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || redirectEn) begin
            outValid <= 1'b0;
        end else if (take) begin
            outValid <= 1'b1;
        end else if (decodeOut.ready) begin
            outValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            decodeOut.op        <= opNext;
            decodeOut.rs1       <= inst[19:15];
            decodeOut.rs2       <= inst[24:20];
            decodeOut.rd        <= inst[11:7];
            decodeOut.imm       <= (opNext == cpuPkg::NOP) ? '0 : immNext;
            decodeOut.pc        <= fetchIn.pc;
            decodeOut.predTaken <= fetchIn.predTaken;
        end
    end

endmodule

`default_nettype wire

/* rtl/instFetch.sv */
`timescale 1ns/1ns
`default_nettype none

module instFetch (
    input  wire                  clk,
    input  wire                  rst,
    output logic                 wbCyc,
    output logic                 wbStb,
    output logic                 wbWe,
    output cpuPkg::addrWord      wbAdr,
    input  wire cpuPkg::instWord wbDatI,
    input  wire                  wbAck,
    input  wire                  redirectEn,
    input  wire cpuPkg::addrWord redirectPc,
    fetchIf.fetchSide            fetchOut
);

    typedef enum logic [1:0] {idle, busReq, drain} fetchState;

    fetchState       state;
    fetchState       stateNext;
    cpuPkg::addrWord pc;          // Next fetch address
    cpuPkg::addrWord busAdr;      // Held for the whole bus cycle
    logic            discard;     // Word in flight is from the old path
    logic            canStart;
    logic            keepWord;
    logic            outValid;
    logic [6:0]      opcode;
    cpuPkg::immWord  jOff;
    cpuPkg::immWord  bOff;
    logic            predTake;
    cpuPkg::addrWord predPc;

    assign wbCyc = (state == busReq);
    assign wbStb = (state == busReq);
    assign wbWe  = 1'b0;
    assign wbAdr = busAdr;

    assign fetchOut.valid = outValid;
    assign canStart = (!outValid || fetchOut.ready) && !redirectEn;
    assign keepWord = (state == busReq) && wbAck && !discard && !redirectEn;

    // ***********************************************************
    // Static prediction on the returning word
    // ***********************************************************
    assign opcode = wbDatI[6:0];
    assign jOff = {{12{wbDatI[31]}}, wbDatI[19:12], wbDatI[20], wbDatI[30:21], 1'b0};
    assign bOff = {{20{wbDatI[31]}}, wbDatI[7], wbDatI[30:25], wbDatI[11:8], 1'b0};

    always_comb begin
        predTake = 1'b0;
        predPc   = busAdr + 32'd4;
        if (opcode == cpuPkg::OP_JAL) begin
            predTake = 1'b1;
            predPc   = busAdr + jOff;
        end else if (opcode == cpuPkg::OP_BRANCH && wbDatI[31]) begin
            predTake = 1'b1;                 // Backward branch
            predPc   = busAdr + bOff;
        end
    end

    always_comb begin
        stateNext = state;
        case (state)
            idle:    if (canStart) stateNext = busReq;
            busReq:  if (wbAck) stateNext = drain;
            drain:   stateNext = canStart ? busReq : idle;
            default: stateNext = idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= idle;
            pc       <= cpuPkg::RESET_PC;
            discard  <= 1'b0;
            outValid <= 1'b0;
        end else begin
            state   <= stateNext;
            discard <= (state == busReq && !wbAck) ? (discard || redirectEn) : 1'b0;
            if (redirectEn) begin
                pc <= redirectPc;
            end else if (keepWord) begin
                pc <= predPc;
            end
            if (redirectEn) begin
                outValid <= 1'b0;
            end else if (keepWord) begin
                outValid <= 1'b1;
            end else if (fetchOut.ready) begin
                outValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state != busReq && stateNext == busReq) begin
            busAdr <= pc;
        end
        if (keepWord) begin
            fetchOut.inst      <= wbDatI;
            fetchOut.pc        <= busAdr;
            fetchOut.predTaken <= predTake;
        end
    end

    // Wishbone classic master rules
    assert property (@(posedge clk) disable iff (rst) wbStb |-> wbCyc);
    assert property (@(posedge clk) disable iff (rst) !wbWe);
    assert property (@(posedge clk) disable iff (rst) wbStb && wbAck |=> !wbStb);

endmodule

`default_nettype wire

/* rtl/renameStage.sv */
`timescale 1ns/1ns
`default_nettype none

module renameStage (
    input  wire                   clk,
    input  wire                   rst,
    decodeIf.renameSide           decodeIn,
    input  wire                   redirectEn,
    input  wire                   commitEn,
    input  wire                   issueReady,
    output logic                  issueValid,
    output cpuPkg::opKind         issueOp,
    output cpuPkg::robTag         issueRs1Tag,
    output cpuPkg::robTag         issueRs2Tag,
    output cpuPkg::robTag         issueRdTag,
    output logic                  issueRs1Busy,
    output logic                  issueRs2Busy,
    output cpuPkg::regName        issueRd,
    output cpuPkg::immWord        issueImm,
    output cpuPkg::addrWord       issuePc,
    output logic                  issuePredTaken
);

    logic [31:0]                         regBusy;
    cpuPkg::robTag                       regTag [32];
    cpuPkg::regName                      tagRd [cpuPkg::ROB_SIZE];   // rd of each live tag
    cpuPkg::robTag                       head;                       // Oldest live tag
    cpuPkg::robTag                       tail;                       // Next tag to hand out
    logic [$clog2(cpuPkg::ROB_SIZE):0]   liveCount;
    cpuPkg::regName                      commitRd;
    logic                                accept;
    logic                                rs1Busy;
    logic                                rs2Busy;

    assign decodeIn.ready = (!issueValid || issueReady) && (liveCount != cpuPkg::ROB_SIZE);
    assign accept   = decodeIn.valid && decodeIn.ready && !redirectEn;
    assign commitRd = tagRd[head];

    // A mapping retired at this same edge is no longer busy
    assign rs1Busy = regBusy[decodeIn.rs1] && !(commitEn && regTag[decodeIn.rs1] == head);
    assign rs2Busy = regBusy[decodeIn.rs2] && !(commitEn && regTag[decodeIn.rs2] == head);

    // ***********************************************************
    // Alias table and tag queue control
    // ***********************************************************
    always_ff @(posedge clk) begin
        if (rst || redirectEn) begin
            regBusy    <= '0;
            head       <= '0;
            tail       <= '0;
            liveCount  <= '0;
            issueValid <= 1'b0;
        end else begin
            if (commitEn) begin
                head <= head + 1'b1;
                if (regTag[commitRd] == head) regBusy[commitRd] <= 1'b0;
            end
            if (accept) begin
                tail <= tail + 1'b1;
                if (decodeIn.rd != '0) regBusy[decodeIn.rd] <= 1'b1;   // x0 stays free
            end
            if (accept && !commitEn) begin
                liveCount <= liveCount + 1'b1;
            end else if (!accept && commitEn) begin
                liveCount <= liveCount - 1'b1;
            end
            if (accept) begin
                issueValid <= 1'b1;
            end else if (issueReady) begin
                issueValid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            tagRd[tail] <= decodeIn.rd;
            if (decodeIn.rd != '0) regTag[decodeIn.rd] <= tail;
            issueOp        <= decodeIn.op;
            issueRs1Busy   <= rs1Busy;
            issueRs2Busy   <= rs2Busy;
            issueRs1Tag    <= rs1Busy ? regTag[decodeIn.rs1] : '0;
            issueRs2Tag    <= rs2Busy ? regTag[decodeIn.rs2] : '0;
            issueRdTag     <= tail;
            issueRd        <= decodeIn.rd;
            issueImm       <= decodeIn.imm;
            issuePc        <= decodeIn.pc;
            issuePredTaken <= decodeIn.predTaken;
        end
    end

    assert property (@(posedge clk) disable iff (rst) commitEn |-> liveCount != '0);
    assert property (@(posedge clk) disable iff (rst)
        issueValid && !issueReady && !redirectEn |=> issueValid && $stable({issueOp,
            issueRs1Tag, issueRs2Tag, issueRdTag, issueRd, issueImm, issuePc}));

endmodule

`default_nettype wire

/* sim.f */
rtl/cpuPkg.sv
rtl/fetchIf.sv
rtl/decodeIf.sv
rtl/instFetch.sv
rtl/instDecoder.sv
rtl/renameStage.sv
rtl/frontEnd.sv
testbench/tbClock.sv
testbench/tbFrontEnd.sv

/* testbench/tbClock.sv */
`timescale 1ns/1ns
`default_nettype none

module tbClock (
    output logic clk,
    output logic rst
);

    initial clk = 1'b0;
    always #20 clk = ~clk;      // 40 ns period

    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        #5;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

/* testbench/tbFrontEnd.sv */
`timescale 1ns/1ns
`default_nettype none

module tbFrontEnd;

    localparam int TIMEOUT = 4000;  // Five short tests need well under 1000 cycles

    logic clk, rst;
    logic wbCyc, wbStb, wbWe, wbAck;
    cpuPkg::addrWord wbAdr, redirectPc, issuePc, expPc;
    cpuPkg::instWord wbDatI;
    logic redirectEn, commitEn, issueReady, issueValid;
    cpuPkg::opKind issueOp, heldOp;
    cpuPkg::robTag issueRs1Tag, issueRs2Tag, issueRdTag, heldRdTag;
    logic issueRs1Busy, issueRs2Busy, issuePredTaken;
    cpuPkg::regName issueRd;
    cpuPkg::immWord issueImm, heldImm;
    cpuPkg::addrWord heldPc;

    cpuPkg::instWord mem [256];
    logic [31:0] rngMem, rngReady;
    int ackDelay, cycles, checks, errors, issued, allocM, headM;
    logic holding;
    logic busyM [32];
    logic [2:0] tagM [32];
    logic [4:0] robRdM [8];

    tbClock i_tbClock (.clk, .rst);

    frontEnd i_frontEnd (
        .clk, .rst, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatI, .wbAck,
        .redirectEn, .redirectPc, .commitEn, .issueReady,
        .issueValid, .issueOp, .issueRs1Tag, .issueRs2Tag, .issueRdTag,
        .issueRs1Busy, .issueRs2Busy, .issueRd, .issueImm, .issuePc, .issuePredTaken
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // ************************************************************
    // Reference decode from the RV32I encoding rules
    // ************************************************************
    function automatic cpuPkg::opKind expOp(input cpuPkg::instWord w);
        logic [2:0] f3;
        f3 = w[14:12];
        expOp = cpuPkg::NOP;
        case (w[6:0])
            cpuPkg::OP_LUI:   expOp = cpuPkg::LUI;
            cpuPkg::OP_AUIPC: expOp = cpuPkg::AUIPC;
            cpuPkg::OP_JAL:   expOp = cpuPkg::JAL;
            cpuPkg::OP_JALR:  expOp = cpuPkg::JALR;
            cpuPkg::OP_BRANCH:
                case (f3)
                    3'd0: expOp = cpuPkg::BEQ;
                    3'd1: expOp = cpuPkg::BNE;
                    3'd4: expOp = cpuPkg::BLT;
                    3'd5: expOp = cpuPkg::BGE;
                    3'd6: expOp = cpuPkg::BLTU;
                    3'd7: expOp = cpuPkg::BGEU;
                    default: ;
                endcase
            cpuPkg::OP_LOAD:
                case (f3)
                    3'd0: expOp = cpuPkg::LB;
                    3'd1: expOp = cpuPkg::LH;
                    3'd2: expOp = cpuPkg::LW;
                    3'd4: expOp = cpuPkg::LBU;
                    3'd5: expOp = cpuPkg::LHU;
                    default: ;
                endcase
            cpuPkg::OP_STORE:
                case (f3)
                    3'd0: expOp = cpuPkg::SB;
                    3'd1: expOp = cpuPkg::SH;
                    3'd2: expOp = cpuPkg::SW;
                    default: ;
                endcase
            cpuPkg::OP_IMM:
                case (f3)
                    3'd0: expOp = cpuPkg::ADDI;
                    3'd1: expOp = w[30] ? cpuPkg::NOP : cpuPkg::SLLI;
                    3'd2: expOp = cpuPkg::SLTI;
                    3'd3: expOp = cpuPkg::SLTIU;
                    3'd4: expOp = cpuPkg::XORI;
                    3'd5: expOp = w[30] ? cpuPkg::SRAI : cpuPkg::SRLI;
                    3'd6: expOp = cpuPkg::ORI;
                    default: expOp = cpuPkg::ANDI;
                endcase
            cpuPkg::OP_REG:
                case ({w[30], f3})
                    4'h0: expOp = cpuPkg::ADD;
                    4'h8: expOp = cpuPkg::SUB;
                    4'h1: expOp = cpuPkg::SLL;
                    4'h2: expOp = cpuPkg::SLT;
                    4'h3: expOp = cpuPkg::SLTU;
                    4'h4: expOp = cpuPkg::XOR;
                    4'h5: expOp = cpuPkg::SRL;
                    4'hd: expOp = cpuPkg::SRA;
                    4'h6: expOp = cpuPkg::OR;
                    4'h7: expOp = cpuPkg::AND;
                    default: ;
                endcase
            default: ;
        endcase
    endfunction

    function automatic cpuPkg::immWord expImm(input cpuPkg::instWord w);
        case (w[6:0])
            cpuPkg::OP_LUI, cpuPkg::OP_AUIPC: expImm = {w[31:12], 12'h000};
            cpuPkg::OP_JAL: expImm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            cpuPkg::OP_BRANCH: expImm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            cpuPkg::OP_JALR, cpuPkg::OP_LOAD, cpuPkg::OP_IMM:
                expImm = {{20{w[31]}}, w[31:20]};
            cpuPkg::OP_STORE: expImm = {{20{w[31]}}, w[31:25], w[11:7]};
            default: expImm = '0;
        endcase
        if (expOp(w) == cpuPkg::NOP) expImm = '0;
    endfunction

    task automatic checkEqual(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got %h, expected %h at %0t", name, got, exp, $time);
        end
    endtask

    // Compare one issued record with the reference model, then advance it
    task automatic checkRecord();
        cpuPkg::instWord w;
        cpuPkg::immWord imm;
        logic [2:0] tag;
        logic taken, b1, b2;
        w     = mem[expPc[9:2]];
        imm   = expImm(w);
        tag   = allocM[2:0];
        taken = (w[6:0] == cpuPkg::OP_JAL) || (w[6:0] == cpuPkg::OP_BRANCH && imm[31]);
        b1    = busyM[w[19:15]];
        b2    = busyM[w[24:20]];
        checkEqual("issuePc", issuePc, expPc);
        checkEqual("issueOp", issueOp, expOp(w));
        checkEqual("issueRd", issueRd, w[11:7]);
        checkEqual("issueImm", issueImm, imm);
        checkEqual("issuePredTaken", issuePredTaken, taken);
        checkEqual("issueRdTag", issueRdTag, tag);
        checkEqual("issueRs1Busy", issueRs1Busy, b1);
        checkEqual("issueRs2Busy", issueRs2Busy, b2);
        checkEqual("issueRs1Tag", issueRs1Tag, b1 ? tagM[w[19:15]] : 3'd0);
        checkEqual("issueRs2Tag", issueRs2Tag, b2 ? tagM[w[24:20]] : 3'd0);
        if (w[11:7] != 5'd0) begin
            busyM[w[11:7]] = 1'b1;
            tagM[w[11:7]]  = tag;
        end
        robRdM[tag] = w[11:7];
        allocM++;
        issued++;
        expPc = taken ? expPc + imm : expPc + 32'd4;
    endtask

    // Wishbone memory that acks after 1 to 3 cycles
    always @(posedge clk) begin
        #5;
        if (rst) begin
            wbAck = 1'b0;
            ackDelay = 0;
        end else if (wbAck) begin
            checkEqual("wbCyc", wbCyc, 1'b0);   // Bus idles one cycle after each ack
            checkEqual("wbStb", wbStb, 1'b0);
            wbAck = 1'b0;
        end else if (wbStb) begin
            checkEqual("wbCyc", wbCyc, 1'b1);
            checkEqual("wbWe", wbWe, 1'b0);
            if (ackDelay == 0) begin
                wbAck  = 1'b1;
                wbDatI = mem[wbAdr[9:2]];
                rngMem = xorshift(rngMem);
                ackDelay = rngMem % 3;
            end else begin
                ackDelay--;
            end
        end
    end

    // Issue monitor sampled at the falling edge
    always @(negedge clk) begin
        if (!rst && holding) begin
            checkEqual("issueValid", issueValid, 1'b1);
            checkEqual("issuePc", issuePc, heldPc);
            checkEqual("issueOp", issueOp, heldOp);
            checkEqual("issueRdTag", issueRdTag, heldRdTag);
            checkEqual("issueImm", issueImm, heldImm);
        end
        holding   = !rst && issueValid && !issueReady && !redirectEn;
        heldPc    = issuePc;
        heldOp    = issueOp;
        heldRdTag = issueRdTag;
        heldImm   = issueImm;
        if (!rst && issueValid && issueReady && !redirectEn) checkRecord();
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("Timeout after %0d cycles, checks %0d, errors %0d", cycles, checks, errors);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic resetModel(input cpuPkg::addrWord pc);
        expPc  = pc;
        allocM = 0;
        headM  = 0;
        issued = 0;
        for (int r = 0; r < 32; r++) busyM[r] = 1'b0;
    endtask

    task automatic startAt(input cpuPkg::addrWord pc);
        redirectEn = 1'b1;
        redirectPc = pc;
        resetModel(pc);
        cycle();
        redirectEn = 1'b0;
    endtask

    task automatic waitIssued(input int n, input logic randomReady);
        while (issued < n) begin
            cycle();
            rngReady   = xorshift(rngReady);
            issueReady = randomReady ? rngReady[0] : 1'b1;
        end
        issueReady = 1'b1;
    endtask

    task automatic commitOldest();
        logic [4:0] r;
        commitEn = 1'b1;
        r = robRdM[headM[2:0]];
        if (tagM[r] == headM[2:0]) busyM[r] = 1'b0;
        headM++;
        cycle();
        commitEn = 1'b0;
    endtask

    // ************************************************************
    // Directed tests
    // ************************************************************
    task automatic testDecode();
        waitIssued(8, 1'b0);     // Runs straight from reset at RESET_PC
    endtask

    task automatic testPredict();
        startAt(32'h100);
        waitIssued(8, 1'b0);
    endtask

    task automatic testRobFull();
        int target;
        startAt(32'h200);
        waitIssued(8, 1'b0);
        repeat (30) cycle();
        checkEqual("issue count", issued, 8);
        repeat (3) begin
            target = issued + 1;
            commitOldest();
            waitIssued(target, 1'b0);
            repeat (10) cycle();
            checkEqual("issue count", issued, target);
        end
    endtask

    task automatic testBackPressure();
        startAt(32'h280);
        waitIssued(8, 1'b1);
    endtask

    task automatic testRedirect();
        startAt(32'h300);
        waitIssued(3, 1'b0);
        startAt(32'h340);
        waitIssued(5, 1'b0);
    endtask

    initial begin
        redirectEn = 1'b0;
        redirectPc = '0;
        commitEn   = 1'b0;
        issueReady = 1'b1;
        wbAck      = 1'b0;
        wbDatI     = '0;
        rngMem     = 32'h5f12;
        rngReady   = xorshift(32'h5f12);
        {cycles, checks, errors, holding} = '0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {12'(i * 3), 5'(i), 3'b000, 5'(i), cpuPkg::OP_IMM};   // addi xi, xi, 3i
        end
        mem[0]   = {20'h12345, 5'd5, cpuPkg::OP_LUI};
        mem[1]   = {20'hfffff, 5'd6, cpuPkg::OP_AUIPC};
        mem[2]   = {12'hffd, 5'd5, 3'b000, 5'd7, cpuPkg::OP_IMM};
        mem[3]   = {7'h20, 5'd6, 5'd7, 3'b000, 5'd8, cpuPkg::OP_REG};
        mem[4]   = {7'h20, 5'd4, 5'd8, 3'b101, 5'd9, cpuPkg::OP_IMM};
        mem[5]   = {12'd8, 5'd9, 3'b010, 5'd10, cpuPkg::OP_LOAD};
        mem[6]   = {7'h7f, 5'd10, 5'd7, 3'b010, 5'h1c, cpuPkg::OP_STORE};
        mem[7]   = {12'd16, 5'd5, 3'b000, 5'd0, cpuPkg::OP_JALR};
        // Jump, forward branch, backward loop
        mem[64]  = {1'b0, 10'd8, 1'b0, 8'd0, 5'd1, cpuPkg::OP_JAL};
        mem[68]  = {12'd1, 5'd1, 3'b000, 5'd2, cpuPkg::OP_IMM};
        mem[69]  = {1'b0, 6'd0, 5'd0, 5'd0, 3'b000, 4'd6, 1'b0, cpuPkg::OP_BRANCH};
        mem[70]  = {1'b1, 6'h3f, 5'd2, 5'd1, 3'b100, 4'b1100, 1'b1, cpuPkg::OP_BRANCH};
        mem[128] = {12'd5, 5'd0, 3'b000, 5'd3, cpuPkg::OP_IMM};
        mem[129] = {12'd1, 5'd3, 3'b000, 5'd4, cpuPkg::OP_IMM};
        mem[136] = {7'h00, 5'd4, 5'd3, 3'b000, 5'd5, cpuPkg::OP_REG};
        // Reads x2 once its writer has committed
        mem[138] = {7'h00, 5'd5, 5'd2, 3'b000, 5'd11, cpuPkg::OP_REG};
        mem[160] = {7'h00, 5'd3, 5'd2, 3'b100, 5'd1, cpuPkg::OP_REG};
        mem[161] = {7'h00, 5'd1, 5'd1, 3'b110, 5'd2, cpuPkg::OP_REG};
        mem[162] = {7'h00, 5'd1, 5'd2, 3'b111, 5'd3, cpuPkg::OP_REG};
        mem[163] = {7'h00, 5'd0, 5'd3, 3'b011, 5'd4, cpuPkg::OP_REG};
        mem[164] = {7'h00, 5'd2, 5'd4, 3'b001, 5'd5, cpuPkg::OP_IMM};
        mem[165] = {7'h00, 5'd4, 5'd5, 3'b101, 5'd6, cpuPkg::OP_REG};
        mem[166] = {12'hfff, 5'd6, 3'b110, 5'd7, cpuPkg::OP_IMM};
        resetModel(cpuPkg::RESET_PC);
        @(negedge rst);
        testDecode();
        testPredict();
        testRobFull();
        testBackPressure();
        testRedirect();
        repeat (5) cycle();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
